//--- build.f
+incdir+include
logic/cpu_pkg.sv
logic/pipe_reg.sv
logic/pipe_ctrl.sv
logic/decode_unit.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/data_ram.sv
logic/cpu_top.sv
verif/cpu_sva.sv
verif/cpu_tb.sv

//--- include/opcodes.svh
`ifndef OPCODES_SVH
`define OPCODES_SVH

// instruction field widths
localparam int OPC_W = 4;
localparam int FN_W  = 6;

// opcode field, instr[15:12]
localparam logic [OPC_W-1:0] OP_BNE   = 4'd0;
localparam logic [OPC_W-1:0] OP_BEQ   = 4'd1;
localparam logic [OPC_W-1:0] OP_ADI   = 4'd4;
localparam logic [OPC_W-1:0] OP_LWD   = 4'd7;
localparam logic [OPC_W-1:0] OP_SWD   = 4'd8;
localparam logic [OPC_W-1:0] OP_JMP   = 4'd9;
localparam logic [OPC_W-1:0] OP_RTYPE = 4'd15;

// funct field of R-type, instr[5:0]
localparam logic [FN_W-1:0] FN_ADD = 6'd0;
localparam logic [FN_W-1:0] FN_SUB = 6'd1;
localparam logic [FN_W-1:0] FN_AND = 6'd2;
localparam logic [FN_W-1:0] FN_ORR = 6'd3;
localparam logic [FN_W-1:0] FN_HLT = 6'd29; // only halt lives under R-type

`endif

//--- logic/cpu_pkg.sv
package cpu_pkg;

`include "opcodes.svh"

localparam int WORD_W     = 16;
localparam int REG_COUNT  = 4;
localparam int DMEM_WORDS = 256;
localparam int DMEM_AW    = $clog2(DMEM_WORDS);
localparam int JT_W       = 12; // jump target bits taken from the instruction

typedef logic [WORD_W-1:0]            word_t;
typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;

typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_PASS} alu_op_t;

typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_DRAIN, ST_DONE} run_state_t;

typedef struct packed {
    alu_op_t alu_op;
    logic    use_imm;
    logic    mem_read;
    logic    mem_write;
    logic    branch_eq;
    logic    branch_ne;
    logic    jump;
    logic    reg_write;
    logic    mem_to_reg;
    logic    halt;
    logic    uses_rs;
    logic    uses_rt;
} ctrl_t;

typedef struct packed {
    logic  valid;
    word_t pc;
    word_t instr;
} if_id_t;

typedef struct packed {
    logic            valid;
    word_t           pc;
    ctrl_t           ctrl;
    word_t           rs_val;
    word_t           rt_val;
    word_t           imm;
    reg_idx_t        rd;
    logic [JT_W-1:0] jtarget_lo;
} id_ex_t;

// branch and alu bits are dropped once execute is done
typedef struct packed {
    logic     valid;
    word_t    pc;
    logic     mem_read;
    logic     mem_write;
    logic     reg_write;
    logic     mem_to_reg;
    logic     halt;
    word_t    alu_result;
    word_t    store_data;
    reg_idx_t rd;
} ex_mem_t;

typedef struct packed {
    logic     valid;
    word_t    pc;
    logic     reg_write;
    logic     halt;
    reg_idx_t rd;
    word_t    result;
} mem_wb_t;

typedef struct packed {
    logic     valid;
    word_t    pc;
    logic     reg_write;
    reg_idx_t rd;
    word_t    value;
} retire_t;

endpackage

//--- logic/cpu_top.sv
`timescale 1ns/1ns

module cpu_top import cpu_pkg::*; (
    input  logic    clk,
    input  logic    reset_n,
    input  logic    start,
    output word_t   i_addr,
    input  word_t   i_data,
    output retire_t retire,
    output logic    halted
);

    word_t           pc;
    logic            fetch_en;
    logic            stall_id;
    logic            squash;
    logic            redirect;
    word_t           target;
    if_id_t          if_id_d, if_id_q;
    id_ex_t          id_ex_d, id_ex_q;
    ex_mem_t         ex_mem_d, ex_mem_q;
    mem_wb_t         mem_wb_d, mem_wb_q;
    ctrl_t           dec_ctrl;
    reg_idx_t        dec_rs, dec_rt, dec_dest;
    word_t           dec_imm;
    logic [JT_W-1:0] dec_jt;
    word_t           rs_val, rt_val;
    word_t           alu_result;
    word_t           ram_rd;

    // pc sits at 0 while fetch is off, so every accepted start begins at 0
    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= target;
        end else if (!fetch_en) begin
            pc <= '0;
        end else if (!stall_id) begin
            pc <= pc + word_t'(1);
        end
    end

    assign i_addr = pc;

    pipe_ctrl u_ctrl (
        .clk, .reset_n, .start,
        .id_valid(if_id_q.valid), .id_halt(dec_ctrl.halt),
        .id_rs(dec_rs), .id_rt(dec_rt),
        .id_uses_rs(dec_ctrl.uses_rs), .id_uses_rt(dec_ctrl.uses_rt),
        .ex_rd(id_ex_q.rd), .ex_reg_write(id_ex_q.ctrl.reg_write),
        .mem_rd(ex_mem_q.rd), .mem_reg_write(ex_mem_q.reg_write),
        .redirect, .wb_halt(mem_wb_q.valid && mem_wb_q.halt),
        .fetch_en, .stall_id, .squash, .halted
    );

    assign if_id_d = '{valid: fetch_en, pc: pc, instr: i_data}; // bubble in DRAIN

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .clk, .reset_n, .hold(stall_id), .squash(squash), .d(if_id_d), .q(if_id_q)
    );

    decode_unit u_dec (
        .instr(if_id_q.instr), .ctrl(dec_ctrl), .rs(dec_rs), .rt(dec_rt),
        .dest(dec_dest), .imm(dec_imm), .jtarget_lo(dec_jt)
    );

    reg_file u_rf (
        .clk, .reset_n, .rs(dec_rs), .rt(dec_rt), .rs_val, .rt_val,
        .we(mem_wb_q.valid && mem_wb_q.reg_write), .wa(mem_wb_q.rd), .wd(mem_wb_q.result)
    );

    always_comb begin
        id_ex_d.valid      = if_id_q.valid;
        id_ex_d.pc         = if_id_q.pc;
        id_ex_d.ctrl       = if_id_q.valid ? dec_ctrl : '0; // stale instr bits decode to nothing
        id_ex_d.rs_val     = rs_val;
        id_ex_d.rt_val     = rt_val;
        id_ex_d.imm        = dec_imm;
        id_ex_d.rd         = dec_dest;
        id_ex_d.jtarget_lo = dec_jt;
    end

    // a stall leaves a bubble behind the held instruction
    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk, .reset_n, .hold(1'b0), .squash(squash || stall_id), .d(id_ex_d), .q(id_ex_q)
    );

    exec_unit u_exe (
        .pc(id_ex_q.pc), .ctrl(id_ex_q.ctrl), .a(id_ex_q.rs_val), .b(id_ex_q.rt_val),
        .imm(id_ex_q.imm), .jtarget_lo(id_ex_q.jtarget_lo),
        .result(alu_result), .redirect, .target
    );

    always_comb begin
        ex_mem_d.valid      = id_ex_q.valid;
        ex_mem_d.pc         = id_ex_q.pc;
        ex_mem_d.mem_read   = id_ex_q.ctrl.mem_read;
        ex_mem_d.mem_write  = id_ex_q.ctrl.mem_write;
        ex_mem_d.reg_write  = id_ex_q.ctrl.reg_write;
        ex_mem_d.mem_to_reg = id_ex_q.ctrl.mem_to_reg;
        ex_mem_d.halt       = id_ex_q.ctrl.halt;
        ex_mem_d.alu_result = alu_result;
        ex_mem_d.store_data = id_ex_q.rt_val;
        ex_mem_d.rd         = id_ex_q.rd;
    end

    pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk, .reset_n, .hold(1'b0), .squash(1'b0), .d(ex_mem_d), .q(ex_mem_q)
    );

    data_ram u_dmem (
        .clk, .addr(ex_mem_q.alu_result[DMEM_AW-1:0]),
        .we(ex_mem_q.valid && ex_mem_q.mem_write), .wd(ex_mem_q.store_data), .rd(ram_rd)
    );

    always_comb begin
        mem_wb_d.valid     = ex_mem_q.valid;
        mem_wb_d.pc        = ex_mem_q.pc;
        mem_wb_d.reg_write = ex_mem_q.reg_write;
        mem_wb_d.halt      = ex_mem_q.halt;
        mem_wb_d.rd        = ex_mem_q.rd;
        mem_wb_d.result    = ex_mem_q.mem_to_reg ? ram_rd : ex_mem_q.alu_result;
    end

    pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk, .reset_n, .hold(1'b0), .squash(1'b0), .d(mem_wb_d), .q(mem_wb_q)
    );

    assign retire = '{valid: mem_wb_q.valid, pc: mem_wb_q.pc, reg_write: mem_wb_q.reg_write,
                      rd: mem_wb_q.rd, value: mem_wb_q.result};

endmodule

//--- logic/data_ram.sv
`timescale 1ns/1ns

module data_ram import cpu_pkg::*; (
    input  logic               clk,
    input  logic [DMEM_AW-1:0] addr,
    input  logic               we,
    input  word_t              wd,
    output word_t              rd
);

    word_t mem [DMEM_WORDS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wd;
        end
    end

    assign rd = mem[addr]; // async read so a load finishes within MEM

endmodule

//--- logic/decode_unit.sv
`timescale 1ns/1ns

module decode_unit import cpu_pkg::*; (
    input  word_t           instr,
    output ctrl_t           ctrl,
    output reg_idx_t        rs,
    output reg_idx_t        rt,
    output reg_idx_t        dest,
    output word_t           imm,
    output logic [JT_W-1:0] jtarget_lo
);

    logic [OPC_W-1:0] opcode;
    logic [FN_W-1:0]  funct;

    assign opcode     = instr[15:12];
    assign funct      = instr[5:0];
    assign rs         = instr[11:10];
    assign rt         = instr[9:8];
    assign imm        = {{(WORD_W-8){instr[7]}}, instr[7:0]};
    assign jtarget_lo = instr[JT_W-1:0];
    assign dest       = (opcode == OP_RTYPE) ? instr[7:6] : instr[9:8]; // I-type writes rt

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_PASS;
        case (opcode)
            OP_RTYPE: begin
                if (funct == FN_HLT) begin
                    ctrl.halt = 1'b1;
                end else if (funct inside {FN_ADD, FN_SUB, FN_AND, FN_ORR}) begin
                    ctrl.reg_write = 1'b1;
                    ctrl.uses_rs   = 1'b1;
                    ctrl.uses_rt   = 1'b1;
                    case (funct)
                        FN_SUB:  ctrl.alu_op = ALU_SUB;
                        FN_AND:  ctrl.alu_op = ALU_AND;
                        FN_ORR:  ctrl.alu_op = ALU_OR;
                        default: ctrl.alu_op = ALU_ADD;
                    endcase
                end
            end
            OP_ADI, OP_LWD: begin
                ctrl.alu_op     = ALU_ADD;
                ctrl.use_imm    = 1'b1;
                ctrl.uses_rs    = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = (opcode == OP_LWD);
                ctrl.mem_to_reg = (opcode == OP_LWD);
            end
            OP_SWD: begin
                ctrl.alu_op    = ALU_ADD; // address is rs + imm
                ctrl.use_imm   = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.uses_rs   = 1'b1;
                ctrl.uses_rt   = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                ctrl.branch_eq = (opcode == OP_BEQ);
                ctrl.branch_ne = (opcode == OP_BNE);
                ctrl.uses_rs   = 1'b1;
                ctrl.uses_rt   = 1'b1;
            end
            OP_JMP: ctrl.jump = 1'b1;
            default: ctrl.alu_op = ALU_PASS; // unknown opcode runs as a nop
        endcase
    end

endmodule

//--- logic/exec_unit.sv
`timescale 1ns/1ns

module exec_unit import cpu_pkg::*; (
    input  word_t           pc,
    input  ctrl_t           ctrl,
    input  word_t           a,
    input  word_t           b,
    input  word_t           imm,
    input  logic [JT_W-1:0] jtarget_lo,
    output word_t           result,
    output logic            redirect,
    output word_t           target
);

    word_t op_b;
    logic  taken;

    assign op_b = ctrl.use_imm ? imm : b;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD: result = a + op_b;
            ALU_SUB: result = a - op_b;
            ALU_AND: result = a & op_b;
            ALU_OR:  result = a | op_b;
            default: result = op_b;
        endcase
    end

    // branches always compare the two registers, never the immediate
    assign taken = (ctrl.branch_eq && a == b) || (ctrl.branch_ne && a != b);

    assign redirect = taken || ctrl.jump; // bubbles carry an all-zero ctrl
    assign target   = ctrl.jump ? {pc[WORD_W-1:JT_W], jtarget_lo}
                                : pc + word_t'(1) + imm;

endmodule

//--- logic/pipe_ctrl.sv
`timescale 1ns/1ns

module pipe_ctrl import cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     start,
    input  logic     id_valid,
    input  logic     id_halt,
    input  reg_idx_t id_rs,
    input  reg_idx_t id_rt,
    input  logic     id_uses_rs,
    input  logic     id_uses_rt,
    input  reg_idx_t ex_rd,
    input  logic     ex_reg_write,
    input  reg_idx_t mem_rd,
    input  logic     mem_reg_write,
    input  logic     redirect,
    input  logic     wb_halt,
    output logic     fetch_en,
    output logic     stall_id,
    output logic     squash,
    output logic     halted
);

    run_state_t state;
    run_state_t state_nxt;
    logic       rs_busy;
    logic       rt_busy;
    logic       hazard;
    logic       halt_in_id;

    // producers in EX or MEM are not yet visible, WB is covered by the regfile bypass
    assign rs_busy = id_uses_rs && ((ex_reg_write && ex_rd == id_rs) ||
                                    (mem_reg_write && mem_rd == id_rs));
    assign rt_busy = id_uses_rt && ((ex_reg_write && ex_rd == id_rt) ||
                                    (mem_reg_write && mem_rd == id_rt));
    assign hazard  = id_valid && (rs_busy || rt_busy);

    assign squash     = redirect;
    assign stall_id   = hazard && !redirect; // the waiting instr gets flushed anyway
    assign halt_in_id = id_valid && id_halt && !redirect;

    // stop fetching in the same cycle the HLT is seen, so nothing younger gets in
    assign fetch_en = (state == ST_RUN) && !halt_in_id;
    assign halted   = (state == ST_DONE);

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE, ST_DONE: begin
                if (start) begin
                    state_nxt = ST_RUN;
                end
            end
            ST_RUN: begin
                if (halt_in_id) begin
                    state_nxt = ST_DRAIN;
                end
            end
            ST_DRAIN: begin
                if (wb_halt) begin
                    state_nxt = ST_DONE; // HLT has retired
                end
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state <= ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

//--- logic/pipe_reg.sv
`timescale 1ns/1ns

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     hold,
    input  logic     squash,
    input  payload_t d,
    output payload_t q
);

    // a cleared payload is a bubble, valid and all write enables low
    always_ff @(posedge clk) begin
        if (reset_n || squash) begin
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ns

module reg_file import cpu_pkg::*; (
    input  logic     clk,
    input  logic     reset_n,
    input  reg_idx_t rs,
    input  reg_idx_t rt,
    output word_t    rs_val,
    output word_t    rt_val,
    input  logic     we,
    input  reg_idx_t wa,
    input  word_t    wd
);

    word_t regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wa] <= wd;
        end
    end

    // write-through, a reader in ID sees the value being written back this cycle
    assign rs_val = (we && wa == rs) ? wd : regs[rs];
    assign rt_val = (we && wa == rt) ? wd : regs[rt];

endmodule

//--- verif/cpu_sva.sv
`timescale 1ns/1ns

module ctrl_checks import cpu_pkg::*; (
    input logic       clk,
    input logic       reset_n,
    input logic       start,
    input logic       redirect,
    input logic       id_valid,
    input logic       wb_halt,
    input logic       fetch_en,
    input logic       stall_id,
    input logic       halted,
    input run_state_t state
);

    int fail_count = 0;

    // DONE is only left through an accepted start
    halted_holds: assert property (@(posedge clk) disable iff (reset_n)
        halted && !start |=> halted)
        else begin
            fail_count++;
            $error("halted dropped without a start");
        end

    // the instr behind a taken branch or jump becomes a bubble in ID
    squash_on_redirect: assert property (@(posedge clk) disable iff (reset_n)
        redirect |=> !id_valid)
        else begin
            fail_count++;
            $error("instr after a redirect was not squashed");
        end

    // fetch stays off while the HLT retires and halted follows one cycle later
    no_fetch_when_halted: assert property (@(posedge clk) disable iff (reset_n)
        wb_halt |-> !fetch_en ##1 (halted && !fetch_en))
        else begin
            fail_count++;
            $error("fetch enabled or halted missing after the HLT retired");
        end

    no_stall_in_idle: assert property (@(posedge clk) disable iff (reset_n)
        state == ST_IDLE |-> !stall_id)
        else begin
            fail_count++;
            $error("stall raised in idle");
        end

endmodule

bind pipe_ctrl ctrl_checks u_ctrl_checks (
    .clk, .reset_n, .start, .redirect, .id_valid, .wb_halt, .fetch_en, .stall_id,
    .halted, .state
);

//--- verif/cpu_tb.sv
`timescale 1ns/1ns

module cpu_tb import cpu_pkg::*; ();

    logic    clk;
    logic    reset_n;
    logic    start;
    word_t   i_addr;
    word_t   i_data;
    retire_t retire;
    logic    halted;

    word_t   imem [256];
    word_t   ref_regs [REG_COUNT];
    word_t   ref_ram [DMEM_WORDS];
    retire_t exp_q [$];
    retire_t exp_ent;
    int      prog_len;
    int      error_count;
    int      check_count;
    int      cycles;
    int      cycle_limit;

    cpu_top dut_i (.clk, .reset_n, .start, .i_addr, .i_data, .retire, .halted);

    assign i_data = imem[i_addr[7:0]]; // answered in the same cycle

    always #2 clk = ~clk;

    function automatic word_t r_type(logic [FN_W-1:0] fn, int rd, int rs, int rt);
        return {OP_RTYPE, 2'(rs), 2'(rt), 2'(rd), fn};
    endfunction

    function automatic word_t i_type(logic [OPC_W-1:0] op, int rt, int rs, int imm);
        return {op, 2'(rs), 2'(rt), 8'(imm)};
    endfunction

    task automatic emit(word_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic clear_program();
        for (int i = 0; i < 256; i++) begin
            imem[i] = r_type(FN_HLT, 0, 0, 0);
        end
        prog_len = 0;
    endtask

    // runs the ISA on its own state, queues the expected retires, returns how many
    function automatic int run_reference();
        word_t   pc;
        word_t   ins;
        word_t   a;
        word_t   b;
        word_t   imm;
        word_t   addr;
        retire_t ent;
        int      n;
        pc = '0;
        n  = 0;
        do begin
            ins  = imem[pc[7:0]];
            a    = ref_regs[ins[11:10]];
            b    = ref_regs[ins[9:8]];
            imm  = {{8{ins[7]}}, ins[7:0]};
            addr = a + imm;
            ent  = '0;
            ent.valid = 1'b1;
            ent.pc    = pc;
            ent.rd    = ins[9:8];
            pc = pc + 1;
            case (ins[15:12])
                OP_RTYPE: begin
                    ent.rd        = ins[7:6];
                    ent.reg_write = (ins[5:0] <= FN_ORR);
                    case (ins[5:0])
                        FN_ADD:  ent.value = a + b;
                        FN_SUB:  ent.value = a - b;
                        FN_AND:  ent.value = a & b;
                        FN_ORR:  ent.value = a | b;
                        default: ent.value = '0;
                    endcase
                end
                OP_ADI: begin
                    ent.reg_write = 1'b1;
                    ent.value     = addr;
                end
                OP_LWD: begin
                    ent.reg_write = 1'b1;
                    ent.value     = ref_ram[addr[7:0]];
                end
                OP_SWD: ref_ram[addr[7:0]] = b;
                OP_BEQ: pc = (a == b) ? pc + imm : pc;
                OP_BNE: pc = (a != b) ? pc + imm : pc;
                OP_JMP: pc = {ent.pc[15:12], ins[11:0]};
                default: ;
            endcase
            if (ent.reg_write) begin
                ref_regs[ent.rd] = ent.value;
            end
            exp_q.push_back(ent);
            n++;
        end while (!(ins[15:12] == OP_RTYPE && ins[5:0] == FN_HLT) && n < 4000);
        return n;
    endfunction

    // compare each retire with the next expected entry
    always @(negedge clk) begin
        if (retire.valid) begin
            check_count++;
            if (halted) begin
                $display("halted was already high while pc %h retired", retire.pc);
                error_count++;
            end
            if (exp_q.size() == 0) begin
                $display("extra retire at pc %h after the expected sequence ended", retire.pc);
                error_count++;
            end else begin
                exp_ent = exp_q.pop_front();
                if (retire.pc !== exp_ent.pc) begin
                    $display("[FAIL] retire.pc expected %h got %h", exp_ent.pc, retire.pc);
                    error_count++;
                end
                if (retire.reg_write !== exp_ent.reg_write) begin
                    $display("[FAIL] retire.reg_write expected %h got %h at pc %h",
                             exp_ent.reg_write, retire.reg_write, exp_ent.pc);
                    error_count++;
                end
                if (exp_ent.reg_write && retire.rd !== exp_ent.rd) begin
                    $display("[FAIL] retire.rd expected %h got %h at pc %h",
                             exp_ent.rd, retire.rd, exp_ent.pc);
                    error_count++;
                end
                if (exp_ent.reg_write && retire.value !== exp_ent.value) begin
                    $display("[FAIL] retire.value expected %h got %h at pc %h",
                             exp_ent.value, retire.value, exp_ent.pc);
                    error_count++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, the DUT did not reach halted", cycles);
            $display("errors: %0d, checks: %0d", error_count, check_count);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // called on a falling edge, returns on one
    task automatic run_program();
        int n;
        n = run_reference();
        cycle_limit += 6 * n + 40;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!halted) begin
            @(negedge clk);
        end
        check_count++;
        if (exp_q.size() != 0) begin
            $display("%0d expected retires never appeared before halted rose", exp_q.size());
            error_count++;
            exp_q.delete();
        end
        repeat (6) begin
            @(negedge clk); // extra retires show up in the compare process
            if (!halted) begin
                $display("halted fell with no start after the program ended");
                error_count++;
            end
        end
    endtask

    // forward-only branches and jumps, so every program reaches its HLT
    task automatic build_random_program();
        int len;
        int kind;
        clear_program();
        len = 8 + $urandom_range(12);
        while (prog_len < len - 1) begin
            kind = $urandom_range(9);
            if (kind < 4) begin
                emit(r_type(FN_W'(kind), $urandom_range(3), $urandom_range(3), $urandom_range(3)));
            end else if (kind < 8) begin
                emit(i_type(kind < 6 ? OP_ADI : (kind == 6 ? OP_LWD : OP_SWD),
                            $urandom_range(3), $urandom_range(3), $urandom_range(255)));
            end else if (kind == 8) begin
                emit(i_type($urandom_range(1) ? OP_BEQ : OP_BNE, $urandom_range(3),
                            $urandom_range(3), $urandom_range(len - 2 - prog_len)));
            end else begin
                emit({OP_JMP, 12'(prog_len + 1 + $urandom_range(len - 2 - prog_len))});
            end
        end
        emit(r_type(FN_HLT, 0, 0, 0));
    endtask

    initial begin
        clk         = 1'b0;
        reset_n     = 1'b1;
        start       = 1'b0;
        error_count = 0;
        check_count = 0;
        cycles      = 0;
        cycle_limit = 60; // reset plus the idle check
        void'($urandom(1));
        for (int i = 0; i < REG_COUNT; i++) begin
            ref_regs[i] = '0;
        end
        clear_program();
        repeat (10) @(negedge clk);
        reset_n = 1'b0;

        repeat (10) begin
            @(negedge clk);
            check_count++;
            if (retire.valid !== 1'b0 || halted !== 1'b0 || i_addr !== '0) begin
                $display("[FAIL] idle retire.valid %h halted %h i_addr %h, expected 0 0 0000",
                         retire.valid, halted, i_addr);
                error_count++;
            end
        end

        // every data word gets its own address, so later loads read known data
        emit(r_type(FN_SUB, 0, 0, 0));
        emit(r_type(FN_SUB, 1, 1, 1));
        repeat (4) emit(i_type(OP_ADI, 1, 1, 64));
        emit(i_type(OP_SWD, 0, 0, 0));
        emit(i_type(OP_ADI, 0, 0, 1));
        emit(i_type(OP_BNE, 1, 0, -3));
        emit(r_type(FN_HLT, 0, 0, 0));
        run_program();

        clear_program();
        emit(r_type(FN_SUB, 0, 0, 0));
        emit(i_type(OP_ADI, 1, 0, 7));
        emit(i_type(OP_ADI, 2, 1, -3));   // r1 used right away
        emit(r_type(FN_ADD, 3, 1, 2));
        emit(r_type(FN_SUB, 0, 3, 1));
        emit(i_type(OP_ADI, 2, 2, 100));
        emit(r_type(FN_AND, 1, 3, 0));    // one instr between
        emit(r_type(FN_ORR, 2, 1, 2));
        emit(i_type(OP_ADI, 3, 3, -128));
        emit(r_type(FN_ADD, 0, 3, 3));
        emit(r_type(FN_HLT, 0, 0, 0));
        run_program();

        clear_program();
        emit(r_type(FN_SUB, 0, 0, 0));
        emit(i_type(OP_ADI, 1, 0, 85));
        emit(i_type(OP_SWD, 1, 0, 10));
        emit(i_type(OP_LWD, 2, 0, 10));   // same word just stored
        emit(r_type(FN_ADD, 3, 2, 1));    // load result used next
        emit(i_type(OP_SWD, 3, 0, 11));
        emit(i_type(OP_LWD, 1, 0, 12));
        emit(i_type(OP_LWD, 2, 0, 11));
        emit(r_type(FN_SUB, 3, 2, 1));
        emit(i_type(OP_SWD, 3, 0, -1));   // wraps to the last word
        emit(i_type(OP_LWD, 0, 0, -1));
        emit(r_type(FN_HLT, 0, 0, 0));
        run_program();

        clear_program();
        emit(r_type(FN_SUB, 0, 0, 0));
        emit(i_type(OP_ADI, 1, 0, 3));
        emit(i_type(OP_ADI, 2, 0, 3));
        emit(i_type(OP_BEQ, 2, 1, 1));    // taken
        emit(i_type(OP_ADI, 3, 0, 99));
        emit(i_type(OP_BNE, 2, 1, 1));    // not taken
        emit(i_type(OP_ADI, 3, 0, 1));
        emit(i_type(OP_BNE, 0, 1, 2));    // taken over two
        emit(i_type(OP_ADI, 3, 3, 50));
        emit(i_type(OP_ADI, 3, 3, 60));
        emit(i_type(OP_BEQ, 0, 1, 1));
        emit({OP_JMP, 12'(prog_len + 3)});
        emit(i_type(OP_ADI, 0, 0, 11));
        emit(i_type(OP_ADI, 1, 1, 12));
        emit(r_type(FN_ADD, 0, 3, 1));
        emit(r_type(FN_HLT, 0, 0, 0));
        run_program();

        // second start sees the counter in RAM and r2 from the first pass
        clear_program();
        emit(i_type(OP_LWD, 1, 0, 20));
        emit(i_type(OP_ADI, 1, 1, 1));
        emit(i_type(OP_SWD, 1, 0, 20));
        emit(r_type(FN_ADD, 2, 2, 1));
        emit(r_type(FN_HLT, 0, 0, 0));
        run_program();
        run_program();

        repeat (20) begin
            build_random_program();
            run_program();
        end

        if (dut_i.u_ctrl.u_ctrl_checks.fail_count != 0) begin
            $display("%0d assertion failures in the pipeline control checks",
                     dut_i.u_ctrl.u_ctrl_checks.fail_count);
            error_count += dut_i.u_ctrl.u_ctrl_checks.fail_count;
        end
        $display("errors: %0d, checks: %0d", error_count, check_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
